/* hdl/rv_core_settings.svh */
//##################################################
// build-wide sizes for the rv32 core
// XLEN must stay 32, decode and store logic assume it
// register count must stay 32, indices are 5 bits
//##################################################

`default_nettype none

`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// data and address width
`define RV_XLEN 32

// byte address of the first fetch
`define RV_RESET_PC 32'h0000_0000

// architectural integer registers
`define RV_REG_COUNT 32

`endif

`default_nettype wire

/* hdl/rv_core_pkg.sv */
//##################################################
// shared types for the rv32 core
// class codes keep the fixed values 0 to 4 and 7
//##################################################

`default_nettype none

package rv_core_pkg;

    // decoder class key with 5 and 6 unused
    typedef enum logic [2:0] {
        class_i   = 3'd0,
        class_n   = 3'd1,
        class_u   = 3'd2,
        class_r   = 3'd3,
        class_s   = 3'd4,
        class_bad = 3'd7
    } inst_class_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_sltu,
        alu_sra,
        alu_and,
        alu_pass_b
    } alu_op_e;

    // anything but sys_none halts the core
    typedef enum logic [1:0] {
        sys_none,
        sys_ecall,
        sys_ebreak,
        sys_illegal
    } sys_op_e;

    typedef enum logic [1:0] {
        cause_none,
        cause_ecall,
        cause_ebreak,
        cause_illegal
    } halt_cause_e;

    typedef enum logic {
        st_run,
        st_halted
    } run_state_e;

endpackage

`default_nettype wire

/* hdl/rv_decode.sv */
//##################################################
// instruction decoder, purely combinational
// subset: addi sltiu srai andi add sub lui auipc
//         sb sh sw ecall ebreak
// unsupported encodings come out as class_bad
//##################################################

`include "rv_core_settings.svh"

`default_nettype none

module rv_decode (
    input  wire [`RV_XLEN-1:0]        inst,
    output logic [4:0]                rd,
    output logic [4:0]                rs1,
    output logic [4:0]                rs2,
    output logic [`RV_XLEN-1:0]       imm,
    output rv_core_pkg::inst_class_e  inst_class,
    output rv_core_pkg::alu_op_e      alu_op,
    output rv_core_pkg::sys_op_e      sys_op,
    output logic                      use_pc,
    output logic                      use_imm,
    output logic [1:0]                store_size
);

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_op_imm = 7'b0010011,
        opc_system = 7'b1110011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_op     = 7'b0110011,
        opc_store  = 7'b0100011
    } opcode_e;

    // system words told apart by bits 31..7
    localparam logic [24:0] ecall_hi  = 25'h000_0000;
    localparam logic [24:0] ebreak_hi = 25'h000_2000;

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_ebreak;

    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign is_ebreak = (inst[6:0] == opc_system) && (inst[31:7] == ebreak_hi);

    assign rd  = inst[11:7];
    assign rs2 = inst[24:20];
    // lui and ebreak read x0, lui then adds imm to zero
    assign rs1 = (inst[6:0] == opc_lui || is_ebreak) ? 5'd0 : inst[19:15];

    // sb 00, sh 01, sw 10
    assign store_size = funct3[1:0];

    always_comb begin
        inst_class = rv_core_pkg::class_bad;
        alu_op     = rv_core_pkg::alu_pass_b;
        sys_op     = rv_core_pkg::sys_none;
        use_pc     = 1'b0;
        use_imm    = 1'b0;
        imm        = '0;
        case (inst[6:0])
            opc_op_imm: begin
                use_imm = 1'b1;
                // sign-extended bits 31..20
                imm = {{20{inst[31]}}, inst[31:20]};
                case (funct3)
                    3'b000: begin
                        inst_class = rv_core_pkg::class_i;
                        alu_op     = rv_core_pkg::alu_add;
                    end
                    3'b011: begin
                        inst_class = rv_core_pkg::class_i;
                        alu_op     = rv_core_pkg::alu_sltu;
                    end
                    3'b101: begin
                        // srli shares funct3, only srai is known
                        if (funct7 == 7'b0100000) begin
                            inst_class = rv_core_pkg::class_i;
                            alu_op     = rv_core_pkg::alu_sra;
                        end
                    end
                    3'b111: begin
                        inst_class = rv_core_pkg::class_i;
                        alu_op     = rv_core_pkg::alu_and;
                    end
                    default: ;
                endcase
            end
            opc_lui, opc_auipc: begin
                inst_class = rv_core_pkg::class_u;
                alu_op     = rv_core_pkg::alu_add;
                use_imm    = 1'b1;
                use_pc     = (inst[6:0] == opc_auipc);
                imm        = {inst[31:12], 12'b0};
            end
            opc_op: begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
                    inst_class = rv_core_pkg::class_r;
                    alu_op     = rv_core_pkg::alu_add;
                end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
                    inst_class = rv_core_pkg::class_r;
                    alu_op     = rv_core_pkg::alu_sub;
                end
            end
            opc_store: begin
                use_imm = 1'b1;
                // split offset, sign from bit 31
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                if (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b010) begin
                    inst_class = rv_core_pkg::class_s;
                    alu_op     = rv_core_pkg::alu_add;
                end
            end
            opc_system: begin
                if (inst[31:7] == ecall_hi) begin
                    inst_class = rv_core_pkg::class_n;
                    sys_op     = rv_core_pkg::sys_ecall;
                end else if (is_ebreak) begin
                    inst_class = rv_core_pkg::class_n;
                    sys_op     = rv_core_pkg::sys_ebreak;
                end
            end
            default: ;
        endcase
        // unknown word or field stops the core
        if (inst_class == rv_core_pkg::class_bad) begin
            sys_op = rv_core_pkg::sys_illegal;
        end
    end

endmodule

`default_nettype wire

/* hdl/rv_regfile.sv */
//##################################################
// integer register file, 2 read and 1 write port
// read is combinational, write lands at the edge
// x0 reads zero, indices assume 32 registers
//##################################################

`include "rv_core_settings.svh"

`default_nettype none

module rv_regfile (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire [4:0]           rs1,
    input  wire [4:0]           rs2,
    input  wire [4:0]           rd,
    input  wire                 wen,
    input  wire [`RV_XLEN-1:0]  wdata,
    output logic [`RV_XLEN-1:0] rs1_data,
    output logic [`RV_XLEN-1:0] rs2_data
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // whole file starts from zero
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 hardwired, no write-through of the same cycle
    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* hdl/rv_alu.sv */
//##################################################
// integer ALU, single cycle
// shift amount is b[4:0], upper b bits ignored
// unknown op code yields zero
//##################################################

`include "rv_core_settings.svh"

`default_nettype none

module rv_alu (
    input  var rv_core_pkg::alu_op_e op,
    input  wire [`RV_XLEN-1:0]       a,
    input  wire [`RV_XLEN-1:0]       b,
    output logic [`RV_XLEN-1:0]      result
);

    logic below;

    // unsigned compare for sltiu
    assign below = (a < b);

    always_comb begin
        case (op)
            rv_core_pkg::alu_add: begin
                result = a + b;
            end
            rv_core_pkg::alu_sub: begin
                result = a - b;
            end
            rv_core_pkg::alu_sltu: begin
                result = {{(`RV_XLEN-1){1'b0}}, below};
            end
            rv_core_pkg::alu_sra: begin
                // sign bit fills from the left
                result = $signed(a) >>> b[4:0];
            end
            rv_core_pkg::alu_and: begin
                result = a & b;
            end
            rv_core_pkg::alu_pass_b: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/rv_store_unit.sv */
//##################################################
// store lane alignment, combinational
// misaligned sh/sw are aligned down, no trap raised
// unselected data lanes are driven as zero
//##################################################

`include "rv_core_settings.svh"

`default_nettype none

module rv_store_unit (
    input  wire                 store_en,
    input  wire [1:0]           size,
    input  wire [`RV_XLEN-1:0]  addr,
    input  wire [`RV_XLEN-1:0]  data,
    output logic                wen,
    output logic [`RV_XLEN-1:0] word_addr,
    output logic [`RV_XLEN-1:0] wdata,
    output logic [3:0]          wmask
);

    logic [1:0] lane;

    assign lane = addr[1:0];
    assign wen  = store_en;
    // memory sees word addresses only
    assign word_addr = {addr[`RV_XLEN-1:2], 2'b00};

    always_comb begin
        case (size)
            2'b00: begin
                // byte into lane 0..3
                wdata = {24'b0, data[7:0]} << {lane, 3'b000};
                wmask = 4'b0001 << lane;
            end
            2'b01: begin
                // half into lower or upper half
                wdata = {16'b0, data[15:0]} << {lane[1], 4'b0000};
                wmask = 4'b0011 << {lane[1], 1'b0};
            end
            default: begin
                wdata = data;
                wmask = 4'b1111;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/rv_pc_control.sv */
//##################################################
// program counter and run/halt state
// any system action or illegal word halts for good
// only reset leaves the halted state
//##################################################

`include "rv_core_settings.svh"

`default_nettype none

module rv_pc_control (
    input  wire                        clk,
    input  wire                        rst_n,
    input  var rv_core_pkg::sys_op_e   sys_op,
    output logic [`RV_XLEN-1:0]        pc,
    output logic                       running,
    output logic                       halted,
    output rv_core_pkg::halt_cause_e   halt_cause
);

    localparam logic [`RV_XLEN-1:0] pc_step = 4;

    rv_core_pkg::run_state_e  state;
    rv_core_pkg::halt_cause_e next_cause;

    // cause follows the decoded system action
    always_comb begin
        case (sys_op)
            rv_core_pkg::sys_ecall:   next_cause = rv_core_pkg::cause_ecall;
            rv_core_pkg::sys_ebreak:  next_cause = rv_core_pkg::cause_ebreak;
            rv_core_pkg::sys_illegal: next_cause = rv_core_pkg::cause_illegal;
            default:                  next_cause = rv_core_pkg::cause_none;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= rv_core_pkg::st_run;
            pc         <= `RV_RESET_PC;
            halt_cause <= rv_core_pkg::cause_none;
        end else if (state == rv_core_pkg::st_run) begin
            if (sys_op == rv_core_pkg::sys_none) begin
                pc <= pc + pc_step;
            end else begin
                // pc stays on the halting word
                state      <= rv_core_pkg::st_halted;
                halt_cause <= next_cause;
            end
        end
    end

    assign running = (state == rv_core_pkg::st_run);
    assign halted  = (state == rv_core_pkg::st_halted);

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
//##################################################
// single-cycle rv32 core top, subset decoder
// fetch and store are combinational, no handshake
// memory must answer inst and accept stores same cycle
// no loads, branches, jumps, CSRs or interrupts
//##################################################

`include "rv_core_settings.svh"

`default_nettype none

module rv_core (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire [`RV_XLEN-1:0]        inst,
    output logic [`RV_XLEN-1:0]       pc,
    output logic                      mem_wen,
    output logic [`RV_XLEN-1:0]       mem_addr,
    output logic [`RV_XLEN-1:0]       mem_wdata,
    output logic [3:0]                mem_wmask,
    output logic                      halted,
    output rv_core_pkg::halt_cause_e  halt_cause
);

    // decode outputs
    logic [4:0]                rd;
    logic [4:0]                rs1;
    logic [4:0]                rs2;
    logic [`RV_XLEN-1:0]       imm;
    rv_core_pkg::inst_class_e  inst_class;
    rv_core_pkg::alu_op_e      alu_op;
    rv_core_pkg::sys_op_e      sys_op;
    logic                      use_pc;
    logic                      use_imm;
    logic [1:0]                store_size;

    // datapath
    logic                running;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic                reg_wen;
    logic                store_en;

    rv_pc_control u_pc_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .sys_op     (sys_op),
        .pc         (pc),
        .running    (running),
        .halted     (halted),
        .halt_cause (halt_cause)
    );

    rv_decode u_decode (
        .inst       (inst),
        .rd         (rd),
        .rs1        (rs1),
        .rs2        (rs2),
        .imm        (imm),
        .inst_class (inst_class),
        .alu_op     (alu_op),
        .sys_op     (sys_op),
        .use_pc     (use_pc),
        .use_imm    (use_imm),
        .store_size (store_size)
    );

    // writeback only for result-producing classes, never once halted
    assign reg_wen = running && (inst_class == rv_core_pkg::class_i ||
                                 inst_class == rv_core_pkg::class_u ||
                                 inst_class == rv_core_pkg::class_r);
    assign store_en = running && (inst_class == rv_core_pkg::class_s);

    rv_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .wen      (reg_wen),
        .wdata    (alu_result),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // auipc adds to pc, I/U/S take the immediate
    assign alu_a = use_pc  ? pc  : rs1_data;
    assign alu_b = use_imm ? imm : rs2_data;

    rv_alu u_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    // alu sum is the byte address for stores
    rv_store_unit u_store_unit (
        .store_en  (store_en),
        .size      (store_size),
        .addr      (alu_result),
        .data      (rs2_data),
        .wen       (mem_wen),
        .word_addr (mem_addr),
        .wdata     (mem_wdata),
        .wmask     (mem_wmask)
    );

endmodule

`default_nettype wire

/* tests/rv_core_tb_tests.svh */
//##################################################
// directed tests included inside the testbench module
// every program stores to 0x100 and ends in a halt
// a store placed after the halt must never show up
//##################################################

`default_nettype none

`ifndef RV_CORE_TB_TESTS_SVH
`define RV_CORE_TB_TESTS_SVH

localparam logic [31:0] word_ecall  = 32'h0000_0073;
localparam logic [31:0] word_ebreak = 32'h0010_0073;

// op-imm where funct3 picks the operation
function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [4:0] rd);
    return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
endfunction

// opc is 0110111 for lui and 0010111 for auipc
function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

// one bit at a time with the sign copied in
function automatic logic [31:0] shift_right_arith(input logic [31:0] v, input logic [4:0] n);
    logic [31:0] r;
    r = v;
    repeat (n) begin
        r = {r[31], r[31:1]};
    end
    return r;
endfunction

task automatic test_reset_and_count();
    clear_program();
    prog[0] = enc_i(12'd5, 5'd0, 3'b000, 5'd1);
    prog[1] = enc_i(12'd7, 5'd1, 3'b000, 5'd1);
    // nop
    prog[2] = enc_i(12'd0, 5'd0, 3'b000, 5'd0);
    prog[3] = enc_s(12'h100, 5'd1, 5'd0, 3'b010);
    prog[4] = word_ebreak;
    prog[5] = enc_s(12'h104, 5'd1, 5'd0, 3'b010);
    expect_store(32'h100, 32'd12, 4'b1111);
    run_program(rv_core_pkg::cause_ebreak);
endtask

task automatic test_itype();
    logic [31:0] r;
    logic [11:0] imm_a;
    logic [11:0] imm_b;
    logic [11:0] imm_c;
    logic [11:0] imm_d;
    logic [4:0]  sh;
    logic [31:0] vals [6];
    clear_program();
    draw_bits(12, r);
    imm_a = r[11:0];
    draw_bits(12, r);
    imm_b = r[11:0];
    draw_bits(12, r);
    imm_c = r[11:0];
    draw_bits(12, r);
    imm_d = r[11:0];
    draw_bits(5, r);
    sh = r[4:0];
    // expected x1..x5 and a zero x0
    vals[0] = sext12(imm_a);
    vals[1] = vals[0] + sext12(imm_b);
    vals[2] = (vals[0] < sext12(imm_c)) ? 32'd1 : 32'd0;
    vals[3] = shift_right_arith(vals[1], sh);
    vals[4] = vals[1] & sext12(imm_d);
    vals[5] = 32'h0;
    prog[0] = enc_i(imm_a, 5'd0, 3'b000, 5'd1);
    prog[1] = enc_i(imm_b, 5'd1, 3'b000, 5'd2);
    prog[2] = enc_i(imm_c, 5'd1, 3'b011, 5'd3);
    prog[3] = enc_i({7'b0100000, sh}, 5'd2, 3'b101, 5'd4);
    prog[4] = enc_i(imm_d, 5'd2, 3'b111, 5'd5);
    // write to x0 is dropped
    prog[5] = enc_i(imm_a, 5'd0, 3'b000, 5'd0);
    for (int k = 0; k < 6; k++) begin
        prog[6 + k] = enc_s(12'h100, (k == 5) ? 5'd0 : 5'(k + 1), 5'd0, 3'b010);
        expect_store(32'h100, vals[k], 4'b1111);
    end
    prog[12] = word_ecall;
    prog[13] = enc_s(12'h100, 5'd1, 5'd0, 3'b010);
    run_program(rv_core_pkg::cause_ecall);
endtask

task automatic test_rtype_utype();
    logic [31:0] r;
    logic [19:0] up;
    logic [11:0] imm_a;
    logic [31:0] vals [5];
    clear_program();
    draw_bits(20, r);
    up = r[19:0];
    draw_bits(12, r);
    imm_a = r[11:0];
    vals[0] = {up, 12'b0};
    vals[1] = sext12(imm_a);
    vals[2] = vals[0] + vals[1];
    vals[3] = vals[0] - vals[1];
    // auipc sits at word 4
    vals[4] = `RV_RESET_PC + 32'd16 + {up, 12'b0};
    prog[0] = enc_u(up, 5'd1, 7'b0110111);
    prog[1] = enc_i(imm_a, 5'd0, 3'b000, 5'd2);
    prog[2] = enc_r(7'b0000000, 5'd2, 5'd1, 5'd3);
    prog[3] = enc_r(7'b0100000, 5'd2, 5'd1, 5'd4);
    prog[4] = enc_u(up, 5'd5, 7'b0010111);
    for (int k = 0; k < 5; k++) begin
        prog[5 + k] = enc_s(12'h100, 5'(k + 1), 5'd0, 3'b010);
        expect_store(32'h100, vals[k], 4'b1111);
    end
    prog[10] = word_ebreak;
    run_program(rv_core_pkg::cause_ebreak);
endtask

task automatic test_store_lanes();
    logic [31:0] word;
    logic [31:0] lane_data;
    logic [3:0]  lane_mask;
    clear_program();
    word = 32'h8765_4321;
    prog[0] = enc_u(20'h87654, 5'd1, 7'b0110111);
    prog[1] = enc_i(12'h321, 5'd1, 3'b000, 5'd1);
    // sb into each byte lane of word 0x100
    for (int k = 0; k < 4; k++) begin
        // low byte placed in lane k and all other lanes zero
        lane_data = {(k == 3) ? word[7:0] : 8'h00, (k == 2) ? word[7:0] : 8'h00,
                     (k == 1) ? word[7:0] : 8'h00, (k == 0) ? word[7:0] : 8'h00};
        lane_mask = {k == 3, k == 2, k == 1, k == 0};
        prog[2 + k] = enc_s(12'h100 | 12'(k), 5'd1, 5'd0, 3'b000);
        expect_store(32'h100 + k, lane_data, lane_mask);
    end
    prog[6] = enc_s(12'h100, 5'd1, 5'd0, 3'b001);
    expect_store(32'h100, {16'b0, word[15:0]}, 4'b0011);
    prog[7] = enc_s(12'h102, 5'd1, 5'd0, 3'b001);
    expect_store(32'h102, {word[15:0], 16'b0}, 4'b1100);
    // word 8 left zero so the core stops there
    prog[9] = enc_s(12'h100, 5'd1, 5'd0, 3'b010);
    run_program(rv_core_pkg::cause_illegal);
endtask

task automatic test_halts();
    // zero word right at reset
    clear_program();
    prog[1] = enc_s(12'h100, 5'd0, 5'd0, 3'b010);
    run_program(rv_core_pkg::cause_illegal);
    // srli is outside the subset
    clear_program();
    prog[0] = enc_i(12'd9, 5'd0, 3'b000, 5'd1);
    prog[1] = enc_i({7'b0000000, 5'd1}, 5'd1, 3'b101, 5'd2);
    prog[2] = enc_s(12'h100, 5'd1, 5'd0, 3'b010);
    run_program(rv_core_pkg::cause_illegal);
endtask

`endif

`default_nettype wire

/* tests/rv_core_tb.sv */
//##################################################
// testbench for the single-cycle rv32 core
// program array acts as a zero-wait instruction memory
// outputs sampled at the falling edge and inputs driven at edge+2
//##################################################

`include "rv_core_settings.svh"

`default_nettype none

module rv_core_tb;

    localparam int half_period  = 20;
    localparam int drive_dly    = 2;
    localparam int reset_cycles = 8;
    localparam int prog_words   = 64;
    localparam int hold_cycles  = 4;
    // 6 tests x 20 instructions x 2 rounded up
    localparam int cycle_limit  = 300;

    logic                     clk;
    logic                     rst_n;
    logic [`RV_XLEN-1:0]      inst;
    logic [`RV_XLEN-1:0]      pc;
    logic                     mem_wen;
    logic [`RV_XLEN-1:0]      mem_addr;
    logic [`RV_XLEN-1:0]      mem_wdata;
    logic [3:0]               mem_wmask;
    logic                     halted;
    rv_core_pkg::halt_cause_e halt_cause;

    // program words indexed by pc[7:2]
    logic [31:0] prog [prog_words];
    // expected stores in program order
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    logic [3:0]  exp_mask_q [$];
    logic [31:0] lfsr_state;
    int          cycle_count = 0;
    int          error_count = 0;

    rv_core dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst       (inst),
        .pc         (pc),
        .mem_wen    (mem_wen),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_wmask  (mem_wmask),
        .halted     (halted),
        .halt_cause (halt_cause)
    );

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // words past the array read as zero and decode as illegal
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr[31:8] == 24'd0) begin
            return prog[addr[7:2]];
        end
        return 32'h0;
    endfunction

    // fetch follows pc within the same cycle
    always @(posedge clk) begin
        #drive_dly;
        inst = fetch_word(pc);
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: core did not halt within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $fatal(1, "cycle limit reached");
        end
    end

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // one step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("ERR %s: got 0x%08h expected 0x%08h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        error_count = error_count + 1;
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic clear_program();
        for (int i = 0; i < prog_words; i++) begin
            prog[i] = 32'h0;
        end
        exp_addr_q.delete();
        exp_data_q.delete();
        exp_mask_q.delete();
    endtask

    // memory sees the word address only
    task automatic expect_store(input logic [31:0] byte_addr, input logic [31:0] data,
                                input logic [3:0] mask);
        exp_addr_q.push_back({byte_addr[31:2], 2'b00});
        exp_data_q.push_back(data);
        exp_mask_q.push_back(mask);
    endtask

    task automatic reset_dut();
        @(posedge clk);
        #drive_dly;
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #drive_dly;
        rst_n = 1'b1;
    endtask

    // resets, runs until halt, checks pc steps, stores and the frozen state
    task automatic run_program(input rv_core_pkg::halt_cause_e exp_cause);
        logic [31:0] exp_pc;
        logic [31:0] stop_pc;
        exp_pc = `RV_RESET_PC;
        reset_dut();
        @(negedge clk);
        compare_value("halted", {31'b0, halted}, 32'h0);
        compare_value("halt_cause", {30'b0, halt_cause}, {30'b0, rv_core_pkg::cause_none});
        while (!halted) begin
            compare_value("pc", pc, exp_pc);
            if (mem_wen) begin
                if (exp_addr_q.size() == 0) begin
                    abort_run("store strobe seen where no store was expected");
                end
                compare_value("mem_addr", mem_addr, exp_addr_q.pop_front());
                compare_value("mem_wdata", mem_wdata, exp_data_q.pop_front());
                compare_value("mem_wmask", {28'b0, mem_wmask}, {28'b0, exp_mask_q.pop_front()});
            end
            exp_pc = exp_pc + 32'd4;
            @(negedge clk);
        end
        if (exp_addr_q.size() != 0) begin
            abort_run("core halted before all expected stores were seen");
        end
        compare_value("halt_cause", {30'b0, halt_cause}, {30'b0, exp_cause});
        // pc stays on the halting word
        stop_pc = exp_pc - 32'd4;
        // a store word under the frozen pc must not reach memory
        prog[stop_pc[7:2]] = enc_s(12'h100, 5'd1, 5'd0, 3'b010);
        repeat (hold_cycles) begin
            compare_value("pc", pc, stop_pc);
            compare_value("mem_wen", {31'b0, mem_wen}, 32'h0);
            compare_value("halted", {31'b0, halted}, 32'h1);
            @(negedge clk);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        inst = 32'h0;
        lfsr_state = 32'd37;
        test_reset_and_count();
        test_itype();
        test_rtype_utype();
        test_store_lanes();
        test_halts();
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

`include "rv_core_tb_tests.svh"

endmodule

`default_nettype wire

/* src.f */
+incdir+hdl
+incdir+tests
hdl/rv_core_pkg.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_store_unit.sv
hdl/rv_pc_control.sv
hdl/rv_core.sv
tests/rv_core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the rv_core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f src.f --top-module rv_core_tb -o rv_core_sim

# a failing check exits nonzero, the log search gives the verdict
./obj_dir/rv_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
